/* tests/rv_vectors.txt */
# P <word address> <instruction>  |  S <store address> <write data> <byte enables>
# C <expected number of stores, decimal>
P 00000000 20000093
P 00000004 FFB00113
P 00000008 00700193
P 0000000C 0020A023
P 00000010 40218233
P 00000014 0040A223
P 00000018 003122B3
P 0000001C 00313333
P 00000020 0050A423
P 00000024 0060A623
P 00000028 0F014393
P 0000002C 40115413
P 00000030 003194B3
P 00000034 12345537
P 00000038 00001597
P 0000003C 0070A823
P 00000040 0080AA23
P 00000044 0090AC23
P 00000048 00A0AE23
P 0000004C 02B0A023
P 00000050 04308023
P 00000054 042080A3
P 00000058 04408123
P 0000005C 048081A3
P 00000060 04209423
P 00000064 04709523
P 00000068 04108603
P 0000006C 0430C683
P 00000070 04A09703
P 00000074 0480D783
P 00000078 04C0A823
P 0000007C 04D0AA23
P 00000080 04E0AC23
P 00000084 04F0AE23
P 00000088 00310463
P 0000008C 0640A023
P 00000090 00318463
P 00000094 0E00A823
P 00000098 00319463
P 0000009C 0670A223
P 000000A0 00311463
P 000000A4 0E00A823
P 000000A8 0021C463
P 000000AC 0680A423
P 000000B0 00314463
P 000000B4 0E00A823
P 000000B8 00315463
P 000000BC 0690A623
P 000000C0 0021D463
P 000000C4 0E00A823
P 000000C8 00316463
P 000000CC 06A0A823
P 000000D0 0021E463
P 000000D4 0E00A823
P 000000D8 0021F463
P 000000DC 06C0AA23
P 000000E0 00317463
P 000000E4 0E00A823
P 000000E8 0080086F
P 000000EC 0E00A823
P 000000F0 0FC00913
P 000000F4 001908E7
P 000000F8 0E00A823
P 000000FC 0700AC23
P 00000100 0710AE23
P 00000104 00000073
S 00000200 FFFFFFFB F
S 00000204 0000000C F
S 00000208 00000001 F
S 0000020C 00000000 F
S 00000210 FFFFFF0B F
S 00000214 FFFFFFFD F
S 00000218 00000380 F
S 0000021C 12345000 F
S 00000220 00001038 F
S 00000240 00000007 1
S 00000240 0000FB00 2
S 00000240 000C0000 4
S 00000240 FD000000 8
S 00000248 0000FFFB 3
S 00000248 FF0B0000 C
S 00000250 FFFFFFFB F
S 00000254 000000FD F
S 00000258 FFFFFF0B F
S 0000025C 0000FFFB F
S 00000260 0000000C F
S 00000264 FFFFFF0B F
S 00000268 FFFFFFFD F
S 0000026C 00000380 F
S 00000270 12345000 F
S 00000274 FFFFFFFB F
S 00000278 000000EC F
S 0000027C 000000F8 F
C 27

/* list.f */
+incdir+common
common/rv_pkg.sv
logic/reg_file.sv
logic/insn_decode.sv
logic/alu.sv
logic/load_store_unit.sv
core/core_sequencer.sv
core/rv_core.sv
tests/mem_responder.sv
tests/tb_rv_core.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_rv_core -f list.f &&
./obj_dir/Vtb_rv_core | tee /dev/stderr | grep -q "^Finished with no errors$" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* tests/tb_rv_core.sv */
module tb_rv_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALT_LIMIT  = 20000;
  localparam int FETCH_LIMIT = 100;
  localparam int QUIET_CYCLES = 20;

  logic             clk;
  logic             rst;
  logic             halt;
  logic             imem_req;
  rv_pkg::word_t    imem_addr;
  logic             imem_ack;
  rv_pkg::word_t    imem_rdata;
  logic             dmem_req;
  logic             dmem_we;
  rv_pkg::word_t    dmem_addr;
  rv_pkg::word_t    dmem_wdata;
  rv_pkg::byte_en_t dmem_be;
  logic             dmem_ack;
  rv_pkg::word_t    dmem_rdata;
  logic             store_seen;
  rv_pkg::word_t    store_addr;
  rv_pkg::word_t    store_data;
  rv_pkg::byte_en_t store_be;
  int               fault_count;

  rv_pkg::word_t prog_addr[$];
  rv_pkg::word_t prog_data[$];
  rv_pkg::word_t exp_addr[$];
  rv_pkg::word_t exp_data[$];
  rv_pkg::word_t exp_be[$];
  int            exp_count;
  int            stores_seen;
  int            check_count;
  int            error_count;

  // previous negedge sample for the hold checks
  logic             prev_ireq;
  logic             prev_iack;
  rv_pkg::word_t    prev_iaddr;
  logic             prev_dreq;
  logic             prev_dack;
  logic             prev_dwe;
  rv_pkg::word_t    prev_daddr;
  rv_pkg::word_t    prev_dwdata;
  rv_pkg::byte_en_t prev_dbe;

  rv_core UUT (
    .clk       (clk),
    .rst       (rst),
    .halt      (halt),
    .imem_req  (imem_req),
    .imem_addr (imem_addr),
    .imem_ack  (imem_ack),
    .imem_rdata(imem_rdata),
    .dmem_req  (dmem_req),
    .dmem_we   (dmem_we),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_be   (dmem_be),
    .dmem_ack  (dmem_ack),
    .dmem_rdata(dmem_rdata)
  );

  mem_responder u_mem (
    .clk        (clk),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_ack   (imem_ack),
    .imem_rdata (imem_rdata),
    .dmem_req   (dmem_req),
    .dmem_we    (dmem_we),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_be    (dmem_be),
    .dmem_ack   (dmem_ack),
    .dmem_rdata (dmem_rdata),
    .store_seen (store_seen),
    .store_addr (store_addr),
    .store_data (store_data),
    .store_be   (store_be),
    .fault_count(fault_count)
  );

  task automatic compare_value(input string name, input rv_pkg::word_t expected,
                               input rv_pkg::word_t actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("ERR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic read_vectors();
    int            fd;
    int            n;
    logic [7:0]    kind;
    string         line;
    rv_pkg::word_t a;
    rv_pkg::word_t d;
    rv_pkg::word_t be;
    fd = $fopen("tests/rv_vectors.txt", "r");
    if (fd == 0) begin
      $display("the vectors file could not be opened");
      error_count++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %c", kind);
      if (n != 1) begin
        break;
      end
      if (kind == "#") begin
        n = $fgets(line, fd);
      end else if (kind == "P") begin
        n = $fscanf(fd, "%h %h", a, d);
        prog_addr.push_back(a);
        prog_data.push_back(d);
      end else if (kind == "S") begin
        n = $fscanf(fd, "%h %h %h", a, d, be);
        exp_addr.push_back(a);
        exp_data.push_back(d);
        exp_be.push_back(be);
      end else if (kind == "C") begin
        n = $fscanf(fd, "%d", exp_count);
      end
    end
    $fclose(fd);
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // request hold under back-pressure and the store log
  always @(negedge clk) begin
    if (!rst) begin
      if (prev_ireq && !prev_iack) begin
        compare_value("imem_req held", 32'(1'b1), 32'(imem_req));
        compare_value("imem_addr held", prev_iaddr, imem_addr);
      end
      if (prev_dreq && !prev_dack) begin
        compare_value("dmem_req held", 32'(1'b1), 32'(dmem_req));
        compare_value("dmem_we held", 32'(prev_dwe), 32'(dmem_we));
        compare_value("dmem_addr held", prev_daddr, dmem_addr);
        compare_value("dmem_wdata held", prev_dwdata, dmem_wdata);
        compare_value("dmem_be held", 32'(prev_dbe), 32'(dmem_be));
      end
      // loads carry no lane enables
      if (dmem_req && !dmem_we) begin
        compare_value("dmem_be on load", 32'h0, 32'(dmem_be));
      end
      if (store_seen) begin
        if (exp_addr.size() == 0) begin
          $display("the core issued a store beyond the expected list");
          error_count++;
        end else begin
          compare_value($sformatf("store %0d address", stores_seen),
                        exp_addr.pop_front(), store_addr);
          compare_value($sformatf("store %0d data", stores_seen),
                        exp_data.pop_front(), store_data);
          compare_value($sformatf("store %0d enables", stores_seen),
                        exp_be.pop_front(), 32'(store_be));
        end
        stores_seen++;
      end
    end
    prev_ireq   <= imem_req;
    prev_iack   <= imem_ack;
    prev_iaddr  <= imem_addr;
    prev_dreq   <= dmem_req;
    prev_dack   <= dmem_ack;
    prev_dwe    <= dmem_we;
    prev_daddr  <= dmem_addr;
    prev_dwdata <= dmem_wdata;
    prev_dbe    <= dmem_be;
  end

  initial begin
    int cycles;
    rst         = 1'b1;
    exp_count   = -1;
    stores_seen = 0;
    check_count = 0;
    error_count = 0;
    read_vectors();
    @(posedge clk);
    #1;
    for (int i = 0; i < prog_addr.size(); i++) begin
      u_mem.mem[prog_addr[i][9:2]] = prog_data[i];
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    compare_value("halt in reset", 32'(1'b0), 32'(halt));
    compare_value("imem_req in reset", 32'(1'b0), 32'(imem_req));
    compare_value("dmem_req in reset", 32'(1'b0), 32'(dmem_req));
    @(posedge clk);
    #1;
    rst = 1'b0;

    cycles = 0;
    @(negedge clk);
    while (!imem_req && cycles < FETCH_LIMIT) begin
      cycles++;
      @(negedge clk);
    end
    if (!imem_req) begin
      $display("the core never requested its first instruction");
      error_count++;
    end else begin
      compare_value("first fetch address", 32'h0000_0000, imem_addr);
    end

    cycles = 0;
    while (!halt && cycles < HALT_LIMIT) begin
      cycles++;
      @(negedge clk);
    end
    if (!halt) begin
      $display("the core did not halt within the cycle limit");
      error_count++;
    end else begin
      // halted core stays quiet
      repeat (QUIET_CYCLES) begin
        @(negedge clk);
        compare_value("halt held", 32'(1'b1), 32'(halt));
        compare_value("imem_req after halt", 32'(1'b0), 32'(imem_req));
        compare_value("dmem_req after halt", 32'(1'b0), 32'(dmem_req));
      end
    end

    compare_value("store count", 32'(exp_count), 32'(stores_seen));
    error_count += fault_count;
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* tests/mem_responder.sv */
module mem_responder (
  input  logic             clk,
  input  logic             imem_req,
  input  rv_pkg::word_t    imem_addr,
  output logic             imem_ack,
  output rv_pkg::word_t    imem_rdata,
  input  logic             dmem_req,
  input  logic             dmem_we,
  input  rv_pkg::word_t    dmem_addr,
  input  rv_pkg::word_t    dmem_wdata,
  input  rv_pkg::byte_en_t dmem_be,
  output logic             dmem_ack,
  output rv_pkg::word_t    dmem_rdata,
  output logic             store_seen,
  output rv_pkg::word_t    store_addr,
  output rv_pkg::word_t    store_data,
  output rv_pkg::byte_en_t store_be,
  output int               fault_count
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DROP_LIMIT = 50;

  rv_pkg::word_t mem [256];
  logic [31:0]   rng_state;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // 0 to 5 cycles before ack
  task automatic draw_delay(output int d);
    rng_state = xorshift(rng_state);
    d = int'(rng_state % 32'd6);
  endtask

  initial begin
    rng_state   = 32'h42bd_01ed;
    fault_count = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h5a00_0000 ^ 32'(i << 2);
    end
  end

  initial begin
    int delay;
    int waited;
    imem_ack   = 1'b0;
    imem_rdata = '0;
    forever begin
      @(negedge clk);
      if (imem_req) begin
        draw_delay(delay);
        repeat (delay) @(posedge clk);
        @(posedge clk);
        #1;
        imem_ack   = 1'b1;
        imem_rdata = mem[imem_addr[9:2]];
        waited = 0;
        @(negedge clk);
        while (imem_req && waited < DROP_LIMIT) begin
          waited++;
          @(negedge clk);
        end
        if (imem_req) begin
          $display("instruction request was not withdrawn after ack");
          fault_count++;
        end
        @(posedge clk);
        #1;
        imem_ack = 1'b0;
      end
    end
  end

  initial begin
    int delay;
    int waited;
    dmem_ack   = 1'b0;
    dmem_rdata = '0;
    store_seen = 1'b0;
    store_addr = '0;
    store_data = '0;
    store_be   = '0;
    forever begin
      @(negedge clk);
      if (dmem_req) begin
        draw_delay(delay);
        repeat (delay) @(posedge clk);
        @(posedge clk);
        #1;
        dmem_ack = 1'b1;
        // read first, then apply the enabled lanes
        dmem_rdata = mem[dmem_addr[9:2]];
        if (dmem_we) begin
          for (int b = 0; b < 4; b++) begin
            if (dmem_be[b]) begin
              mem[dmem_addr[9:2]][8*b +: 8] = dmem_wdata[8*b +: 8];
            end
          end
          store_seen = 1'b1;
          store_addr = dmem_addr;
          store_data = dmem_wdata;
          store_be   = dmem_be;
        end
        @(posedge clk);
        #1;
        store_seen = 1'b0;
        waited = 0;
        @(negedge clk);
        while (dmem_req && waited < DROP_LIMIT) begin
          waited++;
          @(negedge clk);
        end
        if (dmem_req) begin
          $display("data request was not withdrawn after ack");
          fault_count++;
        end
        @(posedge clk);
        #1;
        dmem_ack = 1'b0;
      end
    end
  end

endmodule

/* core/rv_core.sv */
module rv_core (
  input  logic             clk,
  input  logic             rst,
  output logic             halt,
  output logic             imem_req,
  output rv_pkg::word_t    imem_addr,
  input  logic             imem_ack,
  input  rv_pkg::word_t    imem_rdata,
  output logic             dmem_req,
  output logic             dmem_we,
  output rv_pkg::word_t    dmem_addr,
  output rv_pkg::word_t    dmem_wdata,
  output rv_pkg::byte_en_t dmem_be,
  input  logic             dmem_ack,
  input  rv_pkg::word_t    dmem_rdata
);

  rv_pkg::word_t    insn;
  rv_pkg::word_t    pc;
  rv_pkg::word_t    imm;
  rv_pkg::word_t    load_word;
  rv_pkg::word_t    rd_data;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    alu_a;
  rv_pkg::word_t    alu_b;
  rv_pkg::word_t    alu_result;
  rv_pkg::word_t    rd_load_value;
  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::reg_idx_t rd;
  rv_pkg::funct3_t  funct3;
  rv_pkg::alu_op_t  alu_op;
  rv_pkg::byte_en_t lane_be;
  logic             a_is_pc;
  logic             b_is_imm;
  logic             is_load;
  logic             is_store;
  logic             is_branch;
  logic             is_jal;
  logic             is_jalr;
  logic             is_ecall;
  logic             writes_rd;
  logic             rd_we;
  logic             branch_taken;

  // operand select for the alu
  assign alu_a = a_is_pc ? pc : rs1_data;
  assign alu_b = b_is_imm ? imm : rs2_data;

  // loads present no lane enables to the memory
  assign dmem_be = dmem_we ? lane_be : '0;

  core_sequencer u_seq (
    .clk          (clk),
    .rst          (rst),
    .imem_ack     (imem_ack),
    .imem_rdata   (imem_rdata),
    .dmem_ack     (dmem_ack),
    .dmem_rdata   (dmem_rdata),
    .is_load      (is_load),
    .is_store     (is_store),
    .is_branch    (is_branch),
    .is_jal       (is_jal),
    .is_jalr      (is_jalr),
    .is_ecall     (is_ecall),
    .writes_rd    (writes_rd),
    .imm          (imm),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .rd_load_value(rd_load_value),
    .insn         (insn),
    .pc           (pc),
    .imem_req     (imem_req),
    .imem_addr    (imem_addr),
    .dmem_req     (dmem_req),
    .dmem_we      (dmem_we),
    .load_word    (load_word),
    .rd_we        (rd_we),
    .rd_data      (rd_data),
    .halt         (halt)
  );

  insn_decode u_dec (
    .insn     (insn),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .funct3   (funct3),
    .imm      (imm),
    .alu_op   (alu_op),
    .a_is_pc  (a_is_pc),
    .b_is_imm (b_is_imm),
    .is_load  (is_load),
    .is_store (is_store),
    .is_branch(is_branch),
    .is_jal   (is_jal),
    .is_jalr  (is_jalr),
    .is_ecall (is_ecall),
    .writes_rd(writes_rd)
  );

  reg_file u_rf (
    .clk     (clk),
    .rst     (rst),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .rd      (rd),
    .rd_we   (rd_we),
    .rd_data (rd_data)
  );

  alu u_alu (
    .alu_op      (alu_op),
    .a           (alu_a),
    .b           (alu_b),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .funct3      (funct3),
    .result      (alu_result),
    .branch_taken(branch_taken)
  );

  load_store_unit u_lsu (
    .addr         (alu_result),
    .funct3       (funct3),
    .store_value  (rs2_data),
    .load_word    (load_word),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_be      (lane_be),
    .rd_load_value(rd_load_value)
  );

endmodule

/* core/core_sequencer.sv */
`include "rv_consts.svh"

module core_sequencer (
  input  logic          clk,
  input  logic          rst,
  input  logic          imem_ack,
  input  rv_pkg::word_t imem_rdata,
  input  logic          dmem_ack,
  input  rv_pkg::word_t dmem_rdata,
  input  logic          is_load,
  input  logic          is_store,
  input  logic          is_branch,
  input  logic          is_jal,
  input  logic          is_jalr,
  input  logic          is_ecall,
  input  logic          writes_rd,
  input  rv_pkg::word_t imm,
  input  rv_pkg::word_t alu_result,
  input  logic          branch_taken,
  input  rv_pkg::word_t rd_load_value,
  output rv_pkg::word_t insn,
  output rv_pkg::word_t pc,
  output logic          imem_req,
  output rv_pkg::word_t imem_addr,
  output logic          dmem_req,
  output logic          dmem_we,
  output rv_pkg::word_t load_word,
  output logic          rd_we,
  output rv_pkg::word_t rd_data,
  output logic          halt
);

  rv_pkg::seq_state_t state;
  rv_pkg::word_t      pc_plus4;
  rv_pkg::word_t      next_pc;

  assign imem_addr = pc;
  assign pc_plus4  = pc + `RV_PC_INC;

  always_comb begin
    if (is_jalr) begin
      next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
    end else if (is_jal || (is_branch && branch_taken)) begin
      next_pc = pc + imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  // link value, load result or alu output
  always_comb begin
    if (is_jal || is_jalr) begin
      rd_data = pc_plus4;
    end else if (is_load) begin
      rd_data = rd_load_value;
    end else begin
      rd_data = alu_result;
    end
  end

  assign rd_we = (state == rv_pkg::S_WRITEBACK) && writes_rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= rv_pkg::S_FETCH;
      pc       <= `RV_RESET_PC;
      imem_req <= 1'b0;
      dmem_req <= 1'b0;
      dmem_we  <= 1'b0;
      halt     <= 1'b0;
    end else begin
      case (state)
        rv_pkg::S_FETCH: begin
          if (!imem_req && !imem_ack) begin
            imem_req <= 1'b1;
          end else if (imem_req && imem_ack) begin
            imem_req <= 1'b0;
            state    <= rv_pkg::S_FETCH_DONE;
          end
        end
        // memory must drop ack before anything else is issued
        rv_pkg::S_FETCH_DONE: begin
          if (!imem_ack) begin
            state <= rv_pkg::S_EXECUTE;
          end
        end
        rv_pkg::S_EXECUTE: begin
          if (is_ecall) begin
            halt  <= 1'b1;
            state <= rv_pkg::S_HALTED;
          end else if (is_load || is_store) begin
            dmem_req <= 1'b1;
            dmem_we  <= is_store;
            state    <= rv_pkg::S_MEM;
          end else begin
            state <= rv_pkg::S_WRITEBACK;
          end
        end
        rv_pkg::S_MEM: begin
          if (dmem_ack) begin
            dmem_req <= 1'b0;
            dmem_we  <= 1'b0;
            state    <= rv_pkg::S_MEM_DONE;
          end
        end
        rv_pkg::S_MEM_DONE: begin
          if (!dmem_ack) begin
            state <= rv_pkg::S_WRITEBACK;
          end
        end
        rv_pkg::S_WRITEBACK: begin
          pc    <= next_pc;
          state <= rv_pkg::S_FETCH;
        end
        default: begin
          state <= rv_pkg::S_HALTED;
        end
      endcase
    end
  end

  // instruction and load data capture on ack
  always_ff @(posedge clk) begin
    if (state == rv_pkg::S_FETCH && imem_req && imem_ack) begin
      insn <= imem_rdata;
    end
    if (state == rv_pkg::S_MEM && dmem_ack) begin
      load_word <= dmem_rdata;
    end
  end

endmodule

/* logic/load_store_unit.sv */
`include "rv_consts.svh"

module load_store_unit (
  input  rv_pkg::word_t    addr,
  input  rv_pkg::funct3_t  funct3,
  input  rv_pkg::word_t    store_value,
  input  rv_pkg::word_t    load_word,
  output rv_pkg::word_t    dmem_addr,
  output rv_pkg::word_t    dmem_wdata,
  output rv_pkg::byte_en_t dmem_be,
  output rv_pkg::word_t    rd_load_value
);

  logic [1:0]    offset;
  rv_pkg::word_t load_shifted;

  assign offset       = addr[1:0];
  assign dmem_addr    = {addr[`RV_XLEN-1:2], 2'b00};
  assign load_shifted = load_word >> {offset, 3'b000};

  // store data moved into its byte lanes
  always_comb begin
    case (funct3)
      `RV_F3_B, `RV_F3_BU: begin
        dmem_wdata = rv_pkg::word_t'(store_value[7:0]) << {offset, 3'b000};
        dmem_be    = 4'b0001 << offset;
      end
      `RV_F3_H, `RV_F3_HU: begin
        dmem_wdata = rv_pkg::word_t'(store_value[15:0]) << {offset[1], 4'b0000};
        dmem_be    = offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dmem_wdata = store_value;
        dmem_be    = 4'b1111;
      end
    endcase
  end

  // byte or halfword pulled down to bit 0, then extended
  always_comb begin
    case (funct3)
      `RV_F3_B:  rd_load_value = {{24{load_shifted[7]}}, load_shifted[7:0]};
      `RV_F3_BU: rd_load_value = {24'b0, load_shifted[7:0]};
      `RV_F3_H:  rd_load_value = {{16{load_shifted[15]}}, load_shifted[15:0]};
      `RV_F3_HU: rd_load_value = {16'b0, load_shifted[15:0]};
      `RV_F3_W:  rd_load_value = load_word;
      default:   rd_load_value = load_word;
    endcase
  end

endmodule

/* logic/alu.sv */
`include "rv_consts.svh"

module alu (
  input  rv_pkg::alu_op_t alu_op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::funct3_t funct3,
  output rv_pkg::word_t   result,
  output logic            branch_taken
);

  logic [$clog2(`RV_XLEN)-1:0] shamt;

  assign shamt = b[$clog2(`RV_XLEN)-1:0];

  always_comb begin
    case (alu_op)
      rv_pkg::ALU_ADD:    result = a + b;
      rv_pkg::ALU_SUB:    result = a - b;
      rv_pkg::ALU_SLL:    result = a << shamt;
      rv_pkg::ALU_SLT:    result = rv_pkg::word_t'($signed(a) < $signed(b));
      rv_pkg::ALU_SLTU:   result = rv_pkg::word_t'(a < b);
      rv_pkg::ALU_XOR:    result = a ^ b;
      rv_pkg::ALU_SRL:    result = a >> shamt;
      rv_pkg::ALU_SRA:    result = rv_pkg::word_t'($signed(a) >>> shamt);
      rv_pkg::ALU_OR:     result = a | b;
      rv_pkg::ALU_AND:    result = a & b;
      rv_pkg::ALU_PASS_B: result = b;
      default:            result = '0;
    endcase
  end

  // branch condition straight from the register operands
  always_comb begin
    case (funct3)
      `RV_F3_BEQ:  branch_taken = (rs1_data == rs2_data);
      `RV_F3_BNE:  branch_taken = (rs1_data != rs2_data);
      `RV_F3_BLT:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      `RV_F3_BGE:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      `RV_F3_BLTU: branch_taken = (rs1_data < rs2_data);
      `RV_F3_BGEU: branch_taken = (rs1_data >= rs2_data);
      default:     branch_taken = 1'b0;
    endcase
  end

endmodule

/* logic/insn_decode.sv */
`include "rv_consts.svh"

module insn_decode (
  input  rv_pkg::word_t    insn,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::reg_idx_t rd,
  output rv_pkg::funct3_t  funct3,
  output rv_pkg::word_t    imm,
  output rv_pkg::alu_op_t  alu_op,
  output logic             a_is_pc,
  output logic             b_is_imm,
  output logic             is_load,
  output logic             is_store,
  output logic             is_branch,
  output logic             is_jal,
  output logic             is_jalr,
  output logic             is_ecall,
  output logic             writes_rd
);

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic       alt;

  // funct3 to alu op, alt picks sub (reg-reg only) and sra
  function automatic rv_pkg::alu_op_t f3_to_op(input rv_pkg::funct3_t f3, input logic alt_f7,
                                               input logic reg_reg);
    case (f3)
      `RV_F3_ADD:  return (alt_f7 && reg_reg) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      `RV_F3_SLL:  return rv_pkg::ALU_SLL;
      `RV_F3_SLT:  return rv_pkg::ALU_SLT;
      `RV_F3_SLTU: return rv_pkg::ALU_SLTU;
      `RV_F3_XOR:  return rv_pkg::ALU_XOR;
      `RV_F3_SR:   return alt_f7 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      `RV_F3_OR:   return rv_pkg::ALU_OR;
      default:     return rv_pkg::ALU_AND;
    endcase
  endfunction

  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];
  assign alt    = (funct7 == `RV_F7_ALT);

  assign is_load   = (opcode == `RV_OP_LOAD);
  assign is_store  = (opcode == `RV_OP_STORE);
  assign is_branch = (opcode == `RV_OP_BRANCH);
  assign is_jal    = (opcode == `RV_OP_JAL);
  assign is_jalr   = (opcode == `RV_OP_JALR);
  assign is_ecall  = (opcode == `RV_OP_SYSTEM) && (insn[31:7] == '0);

  always_comb begin
    imm       = '0;
    alu_op    = rv_pkg::ALU_ADD;
    a_is_pc   = 1'b0;
    b_is_imm  = 1'b1;
    writes_rd = 1'b0;
    case (opcode)
      `RV_OP_LOAD, `RV_OP_JALR: begin
        imm       = {{20{insn[31]}}, insn[31:20]};
        writes_rd = 1'b1;
      end
      `RV_OP_REGIMM: begin
        imm       = {{20{insn[31]}}, insn[31:20]};
        alu_op    = f3_to_op(funct3, alt, 1'b0);
        writes_rd = 1'b1;
      end
      `RV_OP_REGREG: begin
        alu_op    = f3_to_op(funct3, alt, 1'b1);
        b_is_imm  = 1'b0;
        writes_rd = 1'b1;
      end
      `RV_OP_STORE: begin
        imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
      end
      `RV_OP_BRANCH: begin
        imm      = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
        b_is_imm = 1'b0;
      end
      `RV_OP_JAL: begin
        imm       = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
        a_is_pc   = 1'b1;
        writes_rd = 1'b1;
      end
      `RV_OP_AUIPC: begin
        imm       = {insn[31:12], 12'b0};
        a_is_pc   = 1'b1;
        writes_rd = 1'b1;
      end
      `RV_OP_LUI: begin
        imm       = {insn[31:12], 12'b0};
        alu_op    = rv_pkg::ALU_PASS_B;
        writes_rd = 1'b1;
      end
      // system and unknown opcodes retire without effect
      default: begin
      end
    endcase
  end

endmodule

/* logic/reg_file.sv */
`include "rv_consts.svh"

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  rv_pkg::reg_idx_t rd,
  input  logic             rd_we,
  input  rv_pkg::word_t    rd_data
);

  rv_pkg::word_t regs [`RV_NUM_REGS];

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 is cleared at reset and never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

/* common/rv_pkg.sv */
`include "rv_consts.svh"

package rv_pkg;

  // data, address and instruction words
  typedef logic [`RV_XLEN-1:0] word_t;

  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

  // bit n enables byte n
  typedef logic [`RV_XLEN/8-1:0] byte_en_t;

  typedef logic [2:0] funct3_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic [2:0] {
    S_FETCH,
    S_FETCH_DONE,
    S_EXECUTE,
    S_MEM,
    S_MEM_DONE,
    S_WRITEBACK,
    S_HALTED
  } seq_state_t;

endpackage

/* common/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// machine word and register file size
`define RV_XLEN 32
`define RV_NUM_REGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// sequential pc step
`define RV_PC_INC 32'd4

// major opcodes
`define RV_OP_LOAD 7'b0000011
`define RV_OP_STORE 7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JALR 7'b1100111
`define RV_OP_JAL 7'b1101111
`define RV_OP_REGIMM 7'b0010011
`define RV_OP_REGREG 7'b0110011
`define RV_OP_SYSTEM 7'b1110011
`define RV_OP_AUIPC 7'b0010111
`define RV_OP_LUI 7'b0110111

// alu funct3
`define RV_F3_ADD 3'b000
`define RV_F3_SLL 3'b001
`define RV_F3_SLT 3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR 3'b100
`define RV_F3_SR 3'b101
`define RV_F3_OR 3'b110
`define RV_F3_AND 3'b111

// branch conditions
`define RV_F3_BEQ 3'b000
`define RV_F3_BNE 3'b001
`define RV_F3_BLT 3'b100
`define RV_F3_BGE 3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

// load/store widths
`define RV_F3_B 3'b000
`define RV_F3_H 3'b001
`define RV_F3_W 3'b010
`define RV_F3_BU 3'b100
`define RV_F3_HU 3'b101

// funct7 for sub and sra
`define RV_F7_ALT 7'b0100000

`endif
